/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
design/regfile.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/cpu_top.sv
verification/tb_clock_gen.sv
verification/cpu_checker.sv
verification/cpu_tb.sv

/* common/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath width
`define REG_SIZE 32

// Register index width
`define REG_ADDR 5

// Architectural registers, register 0 is hard zero
`define REG_COUNT 32

// Instruction word width
`define INSTR_SIZE 32

// Immediate field of the I form
`define IMM_SIZE 16

`endif

/* common/isa_pkg.sv */
`include "cpu_settings.svh"

package isa_pkg;

   localparam int OPCODE_W = 6;
   localparam int FUNCT_W  = 6;
   // Whatever the R form leaves over once the fixed fields are placed
   localparam int SHAMT_W  = `INSTR_SIZE - OPCODE_W - FUNCT_W - 3 * `REG_ADDR;

   typedef enum logic [OPCODE_W-1:0] {
      OP_RTYPE = 6'd0,
      OP_ADDI  = 6'd8,
      OP_ANDI  = 6'd12,
      OP_ORI   = 6'd13
   } opcode_e;

   typedef enum logic [FUNCT_W-1:0] {
      FN_ADD = 6'd32,
      FN_SUB = 6'd34,
      FN_AND = 6'd36,
      FN_OR  = 6'd37,
      FN_SLT = 6'd42
   } funct_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } alu_op_e;

   typedef struct packed {
      opcode_e              opcode;
      logic [`REG_ADDR-1:0] rs;
      logic [`REG_ADDR-1:0] rt;
      logic [`REG_ADDR-1:0] rd;
      logic [SHAMT_W-1:0]   shamt; // Unused by this ALU
      funct_e               funct;
   } instr_r_t;

   typedef struct packed {
      opcode_e              opcode;
      logic [`REG_ADDR-1:0] rs;
      logic [`REG_ADDR-1:0] rt;
      logic [`IMM_SIZE-1:0] imm;
   } instr_i_t;

   // Same word, decoded in R or I form
   typedef union packed {
      instr_r_t r;
      instr_i_t i;
   } instr_u;

endpackage

/* common/pipe_pkg.sv */
`include "cpu_settings.svh"

package pipe_pkg;

   import isa_pkg::*;

   typedef logic [`REG_ADDR-1:0] reg_idx_t;
   typedef logic [`REG_SIZE-1:0] word_t;

   // Decode to execute
   typedef struct packed {
      alu_op_e  alu_op;
      logic     use_imm;   // Second operand is imm, not rt
      word_t    imm;       // Already extended
      reg_idx_t rs_idx;
      reg_idx_t rt_idx;
      word_t    rs_val;
      word_t    rt_val;
      reg_idx_t dst;
   } dec_op_t;

   // One retired instruction, also the forwarding source
   typedef struct packed {
      reg_idx_t dst;
      word_t    data;
   } wb_result_t;

endpackage

/* design/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top
   import isa_pkg::*, pipe_pkg::*;
(
   input  logic       clk,
   input  logic       if_id_reset,
   input  logic       in_valid,
   input  instr_u     in_instr,
   output logic       in_ready,
   output logic       out_valid,
   output wb_result_t out_result,
   input  logic       out_ready
);

   reg_idx_t   rs_idx;
   reg_idx_t   rt_idx;
   word_t      rs_val;
   word_t      rt_val;
   logic       advance;
   logic       wr_en;
   logic       dec_valid;
   dec_op_t    dec_op;
   logic       ex_valid;
   wb_result_t ex_result;

   assign in_ready = advance;

   regfile u_regfile (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .rs_idx      (rs_idx),
      .rt_idx      (rt_idx),
      .rs_val      (rs_val),
      .rt_val      (rt_val),
      .wr_en       (wr_en),
      .wr_result   (out_result)
   );

   decode_stage u_decode (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .advance     (advance),
      .in_valid    (in_valid),
      .in_instr    (in_instr),
      .rs_idx      (rs_idx),
      .rt_idx      (rt_idx),
      .rs_val      (rs_val),
      .rt_val      (rt_val),
      .dec_valid   (dec_valid),
      .dec_op      (dec_op)
   );

   // Forwarding comes straight off the output register
   execute_stage u_execute (
      .dec_valid (dec_valid),
      .dec_op    (dec_op),
      .wb_valid  (out_valid),
      .wb_hold   (out_result),
      .ex_valid  (ex_valid),
      .ex_result (ex_result)
   );

   writeback_stage u_writeback (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .ex_valid    (ex_valid),
      .ex_result   (ex_result),
      .out_ready   (out_ready),
      .out_valid   (out_valid),
      .out_result  (out_result),
      .advance     (advance),
      .wr_en       (wr_en)
   );

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decode_stage
   import isa_pkg::*, pipe_pkg::*;
(
   input  logic     clk,
   input  logic     if_id_reset,
   input  logic     advance,
   input  logic     in_valid,
   input  instr_u   in_instr,
   output reg_idx_t rs_idx,
   output reg_idx_t rt_idx,
   input  word_t    rs_val,
   input  word_t    rt_val,
   output logic     dec_valid,
   output dec_op_t  dec_op
);

   logic    op_ok;
   dec_op_t next_op;
   word_t   imm_sext;
   word_t   imm_zext;

   // rs and rt sit at the same bits in both forms
   assign rs_idx = in_instr.r.rs;
   assign rt_idx = in_instr.r.rt;

   assign imm_sext = {{(`REG_SIZE - `IMM_SIZE){in_instr.i.imm[`IMM_SIZE-1]}}, in_instr.i.imm};
   assign imm_zext = {{(`REG_SIZE - `IMM_SIZE){1'b0}}, in_instr.i.imm};

   always_comb begin
      op_ok          = 1'b1;
      next_op        = '0;
      next_op.alu_op = ALU_ADD;
      next_op.rs_idx = rs_idx;
      next_op.rt_idx = rt_idx;
      next_op.rs_val = rs_val;
      next_op.rt_val = rt_val;
      next_op.dst    = in_instr.r.rd;
      case (in_instr.r.opcode)
         OP_RTYPE: begin
            case (in_instr.r.funct)
               FN_ADD:  next_op.alu_op = ALU_ADD;
               FN_SUB:  next_op.alu_op = ALU_SUB;
               FN_AND:  next_op.alu_op = ALU_AND;
               FN_OR:   next_op.alu_op = ALU_OR;
               FN_SLT:  next_op.alu_op = ALU_SLT;
               default: op_ok = 1'b0; // Unknown funct
            endcase
         end
         OP_ADDI, OP_ANDI, OP_ORI: begin
            next_op.use_imm = 1'b1;
            next_op.dst     = in_instr.i.rt; // I form writes rt
            next_op.imm     = imm_zext;
            if (in_instr.i.opcode == OP_ADDI) begin
               next_op.imm = imm_sext;
            end else if (in_instr.i.opcode == OP_ANDI) begin
               next_op.alu_op = ALU_AND;
            end else begin
               next_op.alu_op = ALU_OR;
            end
         end
         default: op_ok = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         dec_valid <= 1'b0;
      end else if (advance) begin
         dec_valid <= in_valid && op_ok; // Bad encoding leaves a bubble
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         dec_op <= next_op;
      end
   end

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
   import isa_pkg::*, pipe_pkg::*;
(
   input  logic       dec_valid,
   input  dec_op_t    dec_op,
   input  logic       wb_valid,
   input  wb_result_t wb_hold,
   output logic       ex_valid,
   output wb_result_t ex_result
);

   word_t op_a;
   word_t op_b;
   word_t rt_fwd;
   word_t alu_out;

   // Take the record held in writeback when it targets this register
   function automatic word_t fwd_sel(input reg_idx_t idx, input word_t reg_val);
      if (wb_valid && (idx != '0) && (idx == wb_hold.dst)) begin
         return wb_hold.data;
      end
      return reg_val;
   endfunction

   always_comb begin
      op_a   = fwd_sel(dec_op.rs_idx, dec_op.rs_val);
      rt_fwd = fwd_sel(dec_op.rt_idx, dec_op.rt_val);
   end

   assign op_b = dec_op.use_imm ? dec_op.imm : rt_fwd;

   always_comb begin
      case (dec_op.alu_op)
         ALU_ADD: alu_out = op_a + op_b;
         ALU_SUB: alu_out = op_a - op_b;
         ALU_AND: alu_out = op_a & op_b;
         ALU_OR:  alu_out = op_a | op_b;
         ALU_SLT: begin
            // Signed compare, result is 0 or 1
            alu_out = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : word_t'(0);
         end
         default: alu_out = '0;
      endcase
   end

   assign ex_valid       = dec_valid;
   assign ex_result.dst  = dec_op.dst;
   assign ex_result.data = alu_out;

endmodule

/* design/regfile.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module regfile
   import pipe_pkg::*;
(
   input  logic       clk,
   input  logic       if_id_reset,
   input  reg_idx_t   rs_idx,
   input  reg_idx_t   rt_idx,
   output word_t      rs_val,
   output word_t      rt_val,
   input  logic       wr_en,
   input  wb_result_t wr_result
);

   word_t regs [`REG_COUNT];

   // Hard zero first, then the write in flight, then storage
   function automatic word_t read_port(input reg_idx_t idx);
      if (idx == '0) begin
         return '0;
      end
      if (wr_en && (wr_result.dst == idx)) begin
         return wr_result.data;
      end
      return regs[idx];
   endfunction

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (wr_result.dst != '0)) begin
         regs[wr_result.dst] <= wr_result.data;
      end
   end

   // Storage and the write port both feed the reads
   always_comb begin
      rs_val = read_port(rs_idx);
      rt_val = read_port(rt_idx);
   end

endmodule

/* design/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage
   import pipe_pkg::*;
(
   input  logic       clk,
   input  logic       if_id_reset,
   input  logic       ex_valid,
   input  wb_result_t ex_result,
   input  logic       out_ready,
   output logic       out_valid,
   output wb_result_t out_result,
   output logic       advance,
   output logic       wr_en
);

   logic out_fire;

   // Whole pipeline moves when this slot can take a new record
   assign advance  = !out_valid || out_ready;
   assign out_fire = out_valid && out_ready;

   // Retire into the register file on transfer only
   assign wr_en = out_fire && (out_result.dst != '0);

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         out_valid <= 1'b0;
      end else if (advance) begin
         out_valid <= ex_valid;
      end
   end

   // Held stable while the consumer stalls
   always_ff @(posedge clk) begin
      if (advance && ex_valid) begin
         out_result <= ex_result;
      end
   end

endmodule

/* verification/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker
   import pipe_pkg::*;
(
   input logic       clk,
   input logic       if_id_reset,
   input logic       in_ready,
   input logic       out_valid,
   input logic       out_ready,
   input wb_result_t out_result
);

   int assert_fails = 0; // Polled by the testbench

   reset_clears_output: assert property (@(posedge clk) if_id_reset |=> !out_valid)
      else begin
         assert_fails++;
         $error("out_valid high in the cycle after reset");
      end

   // Consumer stall must not disturb the offered record
   stall_holds_result: assert property (@(posedge clk) disable iff (if_id_reset)
      (out_valid && !out_ready) |=> $stable(out_result))
      else begin
         assert_fails++;
         $error("out_result changed while stalled");
      end

   ready_follows_slot: assert property (@(posedge clk) disable iff (if_id_reset)
      in_ready == (!out_valid || out_ready))
      else begin
         assert_fails++;
         $error("in_ready does not follow the writeback slot");
      end

endmodule

/* verification/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb
   import isa_pkg::*, pipe_pkg::*;
();

   typedef struct packed {
      instr_u instr;
      logic   has_result; // Unsupported encodings retire nothing
   } stim_t;

   logic       clk;
   logic       if_id_reset;
   logic       in_valid;
   instr_u     in_instr;
   logic       in_ready;
   logic       out_valid;
   wb_result_t out_result;
   logic       out_ready;

   stim_t       stim [$];
   wb_result_t  expect_q [$];
   word_t       ref_regs [`REG_COUNT];
   logic [31:0] lfsr_state  = 32'hefb0;
   int          cycle_count = 0;
   int          cycle_limit = 0;

   tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(2)) u_clock_gen (
      .clk         (clk),
      .if_id_reset (if_id_reset)
   );

   cpu_top i_cpu_top (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .in_valid    (in_valid),
      .in_instr    (in_instr),
      .in_ready    (in_ready),
      .out_valid   (out_valid),
      .out_result  (out_result),
      .out_ready   (out_ready)
   );

   bind cpu_top cpu_checker u_checker (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .in_ready    (in_ready),
      .out_valid   (out_valid),
      .out_ready   (out_ready),
      .out_result  (out_result)
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32 22 2 1
   endfunction

   task automatic draw_bit(output logic b);
      lfsr_state = lfsr_next(lfsr_state);
      b          = lfsr_state[0];
   endtask

   function automatic instr_u r_op(input logic [5:0] fn, input int rd, input int rs, input int rt);
      instr_u w;
      w          = '0;
      w.r.opcode = OP_RTYPE;
      w.r.rs     = reg_idx_t'(rs);
      w.r.rt     = reg_idx_t'(rt);
      w.r.rd     = reg_idx_t'(rd);
      w.r.funct  = funct_e'(fn);
      return w;
   endfunction

   function automatic instr_u i_op(input logic [5:0] opc, input int rt, input int rs,
                                   input logic [15:0] imm);
      instr_u w;
      w          = '0;
      w.i.opcode = opcode_e'(opc);
      w.i.rs     = reg_idx_t'(rs);
      w.i.rt     = reg_idx_t'(rt);
      w.i.imm    = imm;
      return w;
   endfunction

   task automatic add_entry(input instr_u w, input logic has_result);
      stim_t e;
      e.instr      = w;
      e.has_result = has_result;
      stim.push_back(e);
   endtask

   // Reference rule of the ISA, applied when an instruction is accepted
   function automatic wb_result_t model_exec(input instr_u w);
      wb_result_t res;
      word_t      a;
      word_t      b;
      a        = ref_regs[w.r.rs];
      b        = ref_regs[w.r.rt];
      res.dst  = (w.r.opcode == OP_RTYPE) ? w.r.rd : w.i.rt;
      res.data = '0;
      case ({w.r.opcode, w.r.funct})
         {OP_RTYPE, FN_ADD}: res.data = a + b;
         {OP_RTYPE, FN_SUB}: res.data = a - b;
         {OP_RTYPE, FN_AND}: res.data = a & b;
         {OP_RTYPE, FN_OR}:  res.data = a | b;
         {OP_RTYPE, FN_SLT}: res.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         default: begin
            if (w.i.opcode == OP_ADDI) res.data = a + word_t'($signed(w.i.imm));
            if (w.i.opcode == OP_ANDI) res.data = a & word_t'(w.i.imm);
            if (w.i.opcode == OP_ORI)  res.data = a | word_t'(w.i.imm);
         end
      endcase
      return res;
   endfunction

   task automatic stop_on_failure();
      $display("TESTS FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_result(input wb_result_t got, input wb_result_t exp);
      if (got.dst !== exp.dst) begin
         $display("Mismatch out_result.dst: got %h expected %h", got.dst, exp.dst);
         stop_on_failure();
      end
      if (got.data !== exp.data) begin
         $display("Mismatch out_result.data: got %h expected %h", got.data, exp.data);
         stop_on_failure();
      end
   endtask

   task automatic build_program();
      add_entry(i_op(OP_ADDI, 1, 0, 16'd5), 1'b1);
      add_entry(i_op(OP_ADDI, 2, 0, 16'hfffd), 1'b1); // Negative immediate
      add_entry(r_op(FN_ADD, 3, 1, 2), 1'b1);         // Distances two and one
      add_entry(r_op(FN_SUB, 4, 2, 1), 1'b1);
      add_entry(r_op(FN_SLT, 5, 4, 1), 1'b1);
      add_entry(r_op(FN_SLT, 6, 1, 4), 1'b1);
      add_entry(r_op(FN_SLT, 14, 2, 4), 1'b1);        // Both negative
      add_entry(r_op(FN_SLT, 15, 4, 2), 1'b1);
      add_entry(i_op(OP_ANDI, 7, 2, 16'hf0f0), 1'b1);
      add_entry(i_op(OP_ORI, 8, 0, 16'h8001), 1'b1);
      add_entry(r_op(FN_AND, 9, 2, 8), 1'b1);
      add_entry(r_op(FN_OR, 10, 4, 8), 1'b1);
      add_entry(i_op(OP_ADDI, 0, 1, 16'd7), 1'b1);    // Write to r0 still retires
      add_entry(r_op(FN_ADD, 11, 0, 1), 1'b1);
      add_entry(r_op(FN_OR, 12, 0, 0), 1'b1);
      add_entry(i_op(6'd35, 13, 1, 16'd4), 1'b0);     // Load opcode is not supported
      add_entry(r_op(6'd0, 13, 1, 2), 1'b0);          // Unknown funct
      add_entry(i_op(OP_ADDI, 13, 11, 16'd1), 1'b1);
      add_entry(r_op(FN_ADD, 13, 13, 13), 1'b1);
      add_entry(r_op(FN_SUB, 16, 13, 11), 1'b1);
      add_entry(i_op(OP_ORI, 17, 16, 16'hffff), 1'b1);
      add_entry(i_op(OP_ADDI, 18, 17, 16'h8000), 1'b1);
      add_entry(r_op(FN_SLT, 19, 18, 17), 1'b1);
      add_entry(i_op(OP_ANDI, 20, 4, 16'h8008), 1'b1);
      add_entry(r_op(FN_ADD, 21, 20, 10), 1'b1);
   endtask

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_limit > 0 && cycle_count > cycle_limit) begin
         $display("timeout: results missing");
         stop_on_failure();
      end
   end

   initial begin
      wb_result_t exp;
      logic       bit_a;
      logic       bit_b;
      logic       accepted;
      int         idx;
      in_valid  = 1'b0;
      in_instr  = '0;
      out_ready = 1'b0;
      for (int r = 0; r < `REG_COUNT; r++) begin
         ref_regs[r] = '0;
      end
      build_program();
      cycle_limit = 20 * stim.size() + 50;
      idx         = 0;
      accepted    = 1'b0;
      wait (!if_id_reset);
      while (idx < stim.size() || expect_q.size() != 0) begin
         @(posedge clk);
         #1;
         if (accepted || !in_valid) begin
            accepted = 1'b0;
            draw_bit(bit_a);
            draw_bit(bit_b);
            in_valid = (idx < stim.size()) && (bit_a || bit_b); // Gap about one in four
            if (in_valid) in_instr = stim[idx].instr;
         end
         draw_bit(bit_a);
         draw_bit(bit_b);
         out_ready = bit_a || bit_b;
         @(negedge clk);
         if (i_cpu_top.u_checker.assert_fails != 0) begin
            $display("A handshake assertion failed in the checker");
            stop_on_failure();
         end
         if (out_valid && out_ready) begin
            if (expect_q.size() == 0) begin
               $display("The DUT returned a record that no instruction should produce");
               stop_on_failure();
            end
            exp = expect_q.pop_front();
            check_result(out_result, exp);
         end
         if (in_valid && in_ready) begin
            if (stim[idx].has_result) begin
               exp = model_exec(stim[idx].instr);
               if (exp.dst != '0) ref_regs[exp.dst] = exp.data;
               expect_q.push_back(exp);
            end
            idx++;
            accepted = 1'b1;
         end
      end
      // Drain and make sure nothing extra comes out
      repeat (6) begin
         @(posedge clk);
         #1;
         in_valid  = 1'b0;
         out_ready = 1'b1;
         @(negedge clk);
         if (out_valid) begin
            $display("The DUT returned an extra record after the last expected one");
            stop_on_failure();
         end
      end
      if (i_cpu_top.u_checker.assert_fails != 0) begin
         $display("A handshake assertion failed in the checker");
         stop_on_failure();
      end else begin
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 2
) (
   output logic clk,
   output logic if_id_reset
);

   initial begin
      clk         = 1'b0;
      if_id_reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 if_id_reset = 1'b0; // Release just after an edge
   end

   always #(PERIOD_NS / 2) clk = ~clk;

endmodule
